// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP      = fetch_tb
FILELIST = build.f
LOG      = sim.log

BIN     = obj_dir/V$(TOP)
SOURCES = $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
+incdir+design
design/cpu_types_pkg.sv
design/mem_bus_pkg.sv
design/icache_line_ram.sv
design/icache.sv
design/icache_ctrl_regs.sv
design/fetch_subsystem.sv
sim/tb_clock.sv
sim/fetch_tb.sv

// ==== design/cpu_types_pkg.sv ====
`include "icache_cfg.svh"

package cpu_types_pkg;

    // Instruction or data word
    typedef logic [31:0] word_t;

    // Byte address
    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

    // One cache line, word 3 in the top bits
    typedef word_t [3:0] line_words_t;

    // Two consecutive instructions from one lookup
    typedef struct packed {
        word_t inst0;
        word_t inst1;
        logic  inst1_valid;
    } fetch_result_t;

endpackage

// ==== design/fetch_subsystem.sv ====
`include "icache_cfg.svh"

module fetch_subsystem
    import cpu_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_valid,
    input  addr_t                         pc,
    output logic                          hit,
    output fetch_result_t                 result,
    output sram_req_t                     sram_req,
    input  sram_rsp_t                     sram_rsp,
    input  logic                          reg_we,
    input  logic [`ICACHE_REG_ADDR_W-1:0] reg_addr,
    input  word_t                         reg_wdata,
    output word_t                         reg_rdata
);

    logic hit_event;
    logic fill_event;
    logic flush;

    icache i_icache (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .pc          (pc),
        .hit         (hit),
        .result      (result),
        .sram_req    (sram_req),
        .sram_rsp    (sram_rsp),
        .flush       (flush),
        .hit_event   (hit_event),
        .fill_event  (fill_event)
    );

    // Steers flush and watches cache events
    icache_ctrl_regs i_ctrl_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_we     (reg_we),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .hit_event  (hit_event),
        .fill_event (fill_event),
        .flush      (flush)
    );

endmodule

// ==== design/icache.sv ====
`include "icache_cfg.svh"

module icache
    import cpu_types_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_valid,
    input  addr_t         pc,
    output logic          hit,
    output fetch_result_t result,
    output sram_req_t     sram_req,
    input  sram_rsp_t     sram_rsp,
    input  logic          flush,
    output logic          hit_event,
    output logic          fill_event
);

    // ##############################
    // Lookup
    // ##############################

    logic [`ICACHE_INDEX_W-1:0] pc_index;
    logic [`ICACHE_INDEX_W-1:0] ram_index;
    logic [`ICACHE_TAG_W-1:0]   pc_tag;
    logic [`ICACHE_TAG_W-1:0]   rd_tag;
    logic [1:0]                 pc_offset;
    logic                       rd_valid;
    logic                       tag_match;
    logic                       lookup_miss;
    line_words_t                rd_words;
    line_words_t                wr_words;
    logic                       wr_en;

    refill_state_e              state_q;
    logic [1:0]                 beat_q;
    logic [`ICACHE_ADDR_W-5:0]  line_q;
    word_t [2:0]                fill_buf_q;

    assign pc_index  = pc[`ICACHE_INDEX_W+3:4];
    assign pc_tag    = pc[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W+4];
    assign pc_offset = pc[3:2];

    // Write side takes the latched line, read side follows pc
    assign ram_index = wr_en ? line_q[`ICACHE_INDEX_W-1:0] : pc_index;

    icache_line_ram i_line_ram (
        .clk      (clk),
        .rst      (rst),
        .index    (ram_index),
        .wr_en    (wr_en),
        .wr_tag   (line_q[`ICACHE_ADDR_W-5:`ICACHE_INDEX_W]),
        .wr_words (wr_words),
        .clear    (flush),
        .rd_valid (rd_valid),
        .rd_tag   (rd_tag),
        .rd_words (rd_words)
    );

    assign tag_match   = rd_valid && (rd_tag == pc_tag);
    assign hit         = fetch_valid && (state_q == IDLE) && tag_match;
    assign lookup_miss = fetch_valid && (state_q == IDLE) && !tag_match;

    // Second word only exists inside the same line
    always_comb begin
        result.inst0       = rd_words[pc_offset];
        result.inst1_valid = (pc_offset != 2'd3);
        if (result.inst1_valid) begin
            result.inst1 = rd_words[pc_offset + 2'd1];
        end else begin
            result.inst1 = '0;
        end
    end

    assign hit_event = hit;

    // ##############################
    // Refill
    // ##############################

    // Word 0 goes out in the miss cycle itself
    always_comb begin
        sram_req.req = (state_q == FILL) || lookup_miss;
        if (state_q == FILL) begin
            sram_req.addr = {line_q, beat_q, 2'b00};
        end else begin
            sram_req.addr = {pc[`ICACHE_ADDR_W-1:4], 4'b0000};
        end
    end

    // Beat 3 bypasses the buffer
    assign wr_en      = (state_q == FILL) && (beat_q == 2'd3) && sram_rsp.ok;
    assign wr_words   = {sram_rsp.rdata, fill_buf_q};
    assign fill_event = wr_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (lookup_miss) begin
                        state_q <= FILL;
                        beat_q  <= sram_rsp.ok ? 2'd1 : 2'd0;
                    end
                end
                FILL: begin
                    if (sram_rsp.ok) begin
                        // Wraps back to 0 after the last beat
                        beat_q <= beat_q + 2'd1;
                        if (beat_q == 2'd3) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                    beat_q  <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            line_q <= pc[`ICACHE_ADDR_W-1:4];
        end
        if (sram_req.req && sram_rsp.ok && (beat_q != 2'd3)) begin
            fill_buf_q[beat_q] <= sram_rsp.rdata;
        end
    end

    // ##############################
    // SRAM port rules
    // ##############################

    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        (sram_req.req && !sram_rsp.ok) |=> sram_req.req
    );

    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (sram_req.req && !sram_rsp.ok) |=> $stable(sram_req.addr)
    );

endmodule

// ==== design/icache_cfg.svh ====
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ##############################
// Address split
// ##############################

// Byte address width of the fetch side
`define ICACHE_ADDR_W 32

// 64 sets, direct-mapped
`define ICACHE_INDEX_W 6

// Four words per line, so 4 offset bits
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - 4)

// ##############################
// Control register map
// ##############################

`define ICACHE_REG_ADDR_W 2
`define ICACHE_REG_CTRL   2'd0
`define ICACHE_REG_HITS   2'd1
`define ICACHE_REG_FILLS  2'd2

`endif

// ==== design/icache_ctrl_regs.sv ====
`include "icache_cfg.svh"

module icache_ctrl_regs
    import cpu_types_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          reg_we,
    input  logic [`ICACHE_REG_ADDR_W-1:0] reg_addr,
    input  word_t                         reg_wdata,
    output word_t                         reg_rdata,
    input  logic                          hit_event,
    input  logic                          fill_event,
    output logic                          flush
);

    logic  flush_pend_q;
    logic  flush_last_q;
    logic  wr_flush;
    logic  wr_hits;
    logic  wr_fills;
    word_t hits_q;
    word_t fills_q;

    // ##############################
    // Write decode
    // ##############################

    assign wr_flush = reg_we && (reg_addr == `ICACHE_REG_CTRL) && reg_wdata[0];
    assign wr_hits  = reg_we && (reg_addr == `ICACHE_REG_HITS);
    assign wr_fills = reg_we && (reg_addr == `ICACHE_REG_FILLS);

    // Pending flush waits out a line write and never repeats back to back
    assign flush = flush_pend_q && !fill_event && !flush_last_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            flush_pend_q <= 1'b0;
            flush_last_q <= 1'b0;
        end else begin
            flush_last_q <= flush;
            if (wr_flush) begin
                flush_pend_q <= 1'b1;
            end else if (flush) begin
                flush_pend_q <= 1'b0;
            end
        end
    end

    // ##############################
    // Event counters
    // ##############################

    // Clear by write wins over a same-cycle event
    always_ff @(posedge clk) begin
        if (rst || wr_hits) begin
            hits_q <= '0;
        end else if (hit_event) begin
            hits_q <= hits_q + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || wr_fills) begin
            fills_q <= '0;
        end else if (fill_event) begin
            fills_q <= fills_q + 32'd1;
        end
    end

    always_comb begin
        case (reg_addr)
            `ICACHE_REG_CTRL:  reg_rdata = {31'd0, flush_pend_q};
            `ICACHE_REG_HITS:  reg_rdata = hits_q;
            `ICACHE_REG_FILLS: reg_rdata = fills_q;
            default:           reg_rdata = '0;
        endcase
    end

    a_flush_single: assert property (
        @(posedge clk) disable iff (rst) flush |=> !flush
    );

endmodule

// ==== design/icache_line_ram.sv ====
`include "icache_cfg.svh"

module icache_line_ram
    import cpu_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`ICACHE_INDEX_W-1:0] index,
    input  logic                       wr_en,
    input  logic [`ICACHE_TAG_W-1:0]   wr_tag,
    input  line_words_t                wr_words,
    input  logic                       clear,
    output logic                       rd_valid,
    output logic [`ICACHE_TAG_W-1:0]   rd_tag,
    output line_words_t                rd_words
);

    localparam int SETS = 2 ** `ICACHE_INDEX_W;

    line_words_t              data_mem [SETS];
    logic [`ICACHE_TAG_W-1:0] tag_mem  [SETS];
    logic [SETS-1:0]          valid_q;

    // Asynchronous read
    assign rd_words = data_mem[index];
    assign rd_tag   = tag_mem[index];
    assign rd_valid = valid_q[index];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[index] <= wr_words;
            tag_mem[index]  <= wr_tag;
        end
    end

    // All valid bits drop in one cycle
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[index] <= 1'b1;
        end
    end

    // Control block must keep a flush away from a line write
    a_no_clear_on_write: assert property (
        @(posedge clk) disable iff (rst) !(wr_en && clear)
    );

endmodule

// ==== design/mem_bus_pkg.sv ====
`include "icache_cfg.svh"

package mem_bus_pkg;

    import cpu_types_pkg::*;

    // Level request, held until ok
    typedef struct packed {
        logic  req;
        addr_t addr;
    } sram_req_t;

    // ok strobes once per word
    typedef struct packed {
        logic  ok;
        word_t rdata;
    } sram_rsp_t;

    // Line refill controller
    typedef enum logic {
        IDLE,
        FILL
    } refill_state_e;

endpackage

// ==== sim/fetch_tb.sv ====
`include "icache_cfg.svh"

module fetch_tb
    import cpu_types_pkg::*;
    import mem_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_FETCHES    = 400;
    localparam int TIMEOUT_CYCLES = NUM_FETCHES * 20 + 200;
    localparam int SETS           = 2 ** `ICACHE_INDEX_W;
    localparam int TAG_W          = `ICACHE_TAG_W;

    // Low two bits pick one of four tags in the pool
    localparam logic [TAG_W-1:0] TAG_BASE = TAG_W'('h2A40);

    logic                          clk;
    logic                          rst;
    logic                          fetch_valid;
    addr_t                         pc;
    logic                          hit;
    fetch_result_t                 result;
    sram_req_t                     sram_req;
    sram_rsp_t                     sram_rsp;
    logic                          reg_we;
    logic [`ICACHE_REG_ADDR_W-1:0] reg_addr;
    word_t                         reg_wdata;
    word_t                         reg_rdata;

    logic [31:0] lfsr_q = 32'h2928_3729;
    int          errors;
    int          checks;
    int          cycles;

    logic        mem_ok;
    logic        mem_pending;
    logic [1:0]  wait_cnt;

    logic [TAG_W-1:0] model_tag   [SETS];
    logic             model_valid [SETS];
    int               exp_hits;
    int               exp_fills;

    tb_clock #(.PERIOD_NS(8)) i_clock (.clk(clk));

    fetch_subsystem i_dut (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .pc          (pc),
        .hit         (hit),
        .result      (result),
        .sram_req    (sram_req),
        .sram_rsp    (sram_rsp),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata)
    );

    // ##############################
    // Random source and memory contents
    // ##############################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h0001_0193) ^ 32'h6C3A_91E5;
    endfunction

    // Sets 32 to 47 only, so lines get evicted and reused
    function automatic addr_t random_pc();
        logic [31:0]      r;
        logic [TAG_W-1:0] tag;
        r = take_bits(8);
        tag = TAG_BASE;
        tag[1:0] = r[7:6];
        return {tag, 2'b10, r[5:2], r[1:0], 2'b00};
    endfunction

    // ##############################
    // Checks
    // ##############################

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_result(input addr_t fpc);
        check_word("result.inst0", result.inst0, mem_word(fpc));
        check_bit("result.inst1_valid", result.inst1_valid, fpc[3:2] != 2'd3);
        if (fpc[3:2] != 2'd3) begin
            check_word("result.inst1", result.inst1, mem_word(fpc + 32'd4));
        end
    endtask

    // ##############################
    // SRAM responder
    // ##############################

    // First word of a burst costs one extra cycle, later words 0 to 3 waits
    assign sram_rsp = {mem_ok, mem_word(sram_req.addr)};

    initial begin
        logic [31:0] r;
        logic        next_pending;
        logic [1:0]  next_wait;
        mem_ok      = 1'b0;
        mem_pending = 1'b0;
        wait_cnt    = 2'd0;
        forever begin
            @(negedge clk);
            next_pending = 1'b0;
            next_wait    = 2'd0;
            if (!rst && sram_req.req && !mem_ok) begin
                next_pending = 1'b1;
                if (mem_pending) begin
                    next_wait = wait_cnt - 2'd1;
                end else begin
                    r = take_bits(2);
                    next_wait = r[1:0];
                end
            end else if (!rst && sram_req.req && sram_req.addr[3:2] != 2'd3) begin
                // Burst goes on with the next word
                next_pending = 1'b1;
                r = take_bits(2);
                next_wait = r[1:0];
            end
            @(posedge clk);
            #1;
            mem_pending = next_pending;
            wait_cnt    = next_wait;
            mem_ok      = next_pending && (next_wait == 2'd0);
        end
    end

    // ##############################
    // Stimulus tasks
    // ##############################

    // Entered 1 ns after an edge, leaves at the same point two cycles on
    task automatic send_flush();
        fetch_valid = 1'b0;
        reg_we      = 1'b1;
        reg_addr    = `ICACHE_REG_CTRL;
        reg_wdata   = 32'd1;
        @(posedge clk);
        #1;
        reg_we    = 1'b0;
        reg_wdata = '0;
        // Flush pulse is high now
        @(posedge clk);
        #1;
        for (int s = 0; s < SETS; s++) begin
            model_valid[s] = 1'b0;
        end
    endtask

    task automatic run_fetch(input addr_t fpc);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [TAG_W-1:0]           tag;
        addr_t                      line_base;
        logic                       predict;
        int                         beat;
        idx       = fpc[`ICACHE_INDEX_W+3:4];
        tag       = fpc[`ICACHE_ADDR_W-1:`ICACHE_INDEX_W+4];
        line_base = {fpc[`ICACHE_ADDR_W-1:4], 4'b0000};
        predict   = model_valid[idx] && (model_tag[idx] == tag);
        @(negedge clk);
        check_bit("hit", hit, predict);
        if (!predict) begin
            beat = 0;
            while (beat < 4) begin
                check_bit("sram_req.req", sram_req.req, 1'b1);
                check_word("sram_req.addr", sram_req.addr, line_base + addr_t'(beat * 4));
                check_bit("hit", hit, 1'b0);
                if (sram_rsp.ok) begin
                    beat++;
                end
                @(negedge clk);
            end
            // One cycle after the fourth ok
            check_bit("hit", hit, 1'b1);
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            exp_fills++;
        end
        if (hit) begin
            check_result(fpc);
        end
        exp_hits++;
    endtask

    task automatic read_reg(input logic [`ICACHE_REG_ADDR_W-1:0] a, output word_t v);
        @(posedge clk);
        #1;
        reg_addr = a;
        @(negedge clk);
        v = reg_rdata;
    endtask

    task automatic write_reg(input logic [`ICACHE_REG_ADDR_W-1:0] a, input word_t d);
        @(posedge clk);
        #1;
        reg_we    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(posedge clk);
        #1;
        reg_we    = 1'b0;
        reg_wdata = '0;
    endtask

    // ##############################
    // Main sequence
    // ##############################

    initial begin
        logic [31:0] rnd;
        addr_t       next_pc;
        word_t       value;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        pc          = '0;
        reg_we      = 1'b0;
        reg_addr    = `ICACHE_REG_CTRL;
        reg_wdata   = '0;
        errors      = 0;
        checks      = 0;
        exp_hits    = 0;
        exp_fills   = 0;
        for (int s = 0; s < SETS; s++) begin
            model_valid[s] = 1'b0;
        end

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int n = 0; n < NUM_FETCHES; n++) begin
            @(posedge clk);
            #1;
            rnd = take_bits(4);
            if (rnd[3:0] == 4'd0) begin
                send_flush();
            end
            next_pc     = random_pc();
            fetch_valid = 1'b1;
            pc          = next_pc;
            run_fetch(next_pc);
        end

        @(posedge clk);
        #1;
        fetch_valid = 1'b0;

        // Event counters, then clear by write
        read_reg(`ICACHE_REG_HITS, value);
        check_word("reg_rdata (HITS)", value, word_t'(exp_hits));
        read_reg(`ICACHE_REG_FILLS, value);
        check_word("reg_rdata (FILLS)", value, word_t'(exp_fills));
        write_reg(`ICACHE_REG_HITS, '0);
        read_reg(`ICACHE_REG_HITS, value);
        check_word("reg_rdata (HITS)", value, '0);
        write_reg(`ICACHE_REG_FILLS, '0);
        read_reg(`ICACHE_REG_FILLS, value);
        check_word("reg_rdata (FILLS)", value, '0);

        $display("Errors: %0d in %0d checks, %0d fetches, %0d fills",
                 errors, checks, exp_hits, exp_fills);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d in %0d checks, plus the timeout", errors, checks);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sim/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule
